/* Bender.yml */
package:
  name: shooter

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - shooter_geom_pkg.sv
      - shooter_ctrl_pkg.sv
      - frame_tick_gen.sv
      - ship_movement.sv
      - missile_movement.sv
      - hit_detector.sv
      - shooter_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_shooter.sv

/* frame_tick_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "shooter_params.svh"

module frame_tick_gen (
    input  logic clk,
    input  logic resetN,
    output logic start_of_frame
);

    typedef logic [$clog2(`FRAME_CYCLES)-1:0] cnt_t;

    cnt_t cycle_cnt;
    logic cnt_done;

    // Last clock of the frame
    assign cnt_done = (cycle_cnt == cnt_t'(`FRAME_CYCLES - 1));

    // The counter wraps at the terminal count and the tick is registered,
    // so the first tick appears FRAME_CYCLES clocks after reset release
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            cycle_cnt      <= '0;
            start_of_frame <= 1'b0;
        end else begin
            start_of_frame <= cnt_done;
            if (cnt_done) begin
                cycle_cnt <= '0;
            end else begin
                cycle_cnt <= cycle_cnt + 1'b1;
            end
        end
    end

    // Ship and missile each step once per tick, so a long tick would double step
    assert property (@(posedge clk) disable iff (!resetN)
        start_of_frame |=> !start_of_frame)
        else $error("start_of_frame high for two cycles");

endmodule

`default_nettype wire

/* hit_detector.sv */
`timescale 1ns/1ps
`default_nettype none

`include "shooter_params.svh"

module hit_detector (
    input  logic                         clk,
    input  logic                         resetN,
    input  shooter_geom_pkg::obj_pos_t   missile_pos,
    input  logic                         missile_active,
    input  shooter_geom_pkg::obj_pos_t   target_pos,
    output logic                         collision,
    output shooter_geom_pkg::edge_code_t edge_code
);

    import shooter_geom_pkg::*;

    // Box sides, right and bottom are exclusive
    wide_coord_t m_left;
    wide_coord_t m_right;
    wide_coord_t m_top;
    wide_coord_t m_bottom;
    wide_coord_t t_left;
    wide_coord_t t_right;
    wide_coord_t t_top;
    wide_coord_t t_bottom;
    logic        overlap;

    assign m_left   = wide_coord_t'(missile_pos.x);
    assign m_right  = m_left + wide_coord_t'(`MISSILE_W);
    assign m_top    = wide_coord_t'(missile_pos.y);
    assign m_bottom = m_top + wide_coord_t'(`MISSILE_H);

    assign t_left   = wide_coord_t'(target_pos.x);
    assign t_right  = t_left + wide_coord_t'(`TARGET_W);
    assign t_top    = wide_coord_t'(target_pos.y);
    assign t_bottom = t_top + wide_coord_t'(`TARGET_H);

    // Two boxes overlap when they overlap on both axes
    assign overlap = missile_active
                  && (m_left < t_right) && (t_left < m_right)
                  && (m_top < t_bottom) && (t_top < m_bottom);

    // The missile is removed one edge after the hit, so it still overlaps on
    // that edge; masking with the previous value keeps the hit to one cycle
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            collision <= 1'b0;
        end else begin
            collision <= overlap && !collision;
        end
    end

    // Borders the missile box crosses, nothing while no missile is on screen
    assign edge_code = '{
        top:    missile_active && (m_top < 0),
        bottom: missile_active && (m_bottom > wide_coord_t'(`SCREEN_H)),
        left:   missile_active && (m_left < 0),
        right:  missile_active && (m_right > wide_coord_t'(`SCREEN_W))
    };

    // One target hit gives one hit pulse
    assert property (@(posedge clk) disable iff (!resetN)
        collision |=> !collision)
        else $error("collision high for two cycles");

endmodule

`default_nettype wire

/* missile_movement.sv */
`timescale 1ns/1ps
`default_nettype none

`include "shooter_params.svh"

module missile_movement (
    input  logic                         clk,
    input  logic                         resetN,
    input  logic                         start_of_frame,
    input  logic                         shot,
    input  logic                         collision,
    input  shooter_geom_pkg::edge_code_t edge_code,
    input  shooter_geom_pkg::obj_pos_t   ship_pos,
    output shooter_geom_pkg::obj_pos_t   missile_pos,
    output logic                         missile_active
);

    import shooter_geom_pkg::*;
    import shooter_ctrl_pkg::*;

    // Position with FP_SHIFT fraction bits, a speed of 64 is one pixel per frame
    typedef logic signed [31:0] fixed_t;

    fixed_t         x_fp;
    fixed_t         y_fp;
    fixed_t         launch_x;
    fixed_t         launch_y;
    logic           shot_latch;
    logic           launch;
    logic           remove;
    missile_state_e state;

    // Launch point is the ship corner plus the offset, scaled to fixed point
    assign launch_x = (fixed_t'(ship_pos.x) + fixed_t'(`MISSILE_X_OFFSET)) <<< `FP_SHIFT;
    assign launch_y = (fixed_t'(ship_pos.y) + fixed_t'(`MISSILE_Y_OFFSET)) <<< `FP_SHIFT;

    // A latched shot fires on the frame tick, even over a missile in flight
    assign launch = start_of_frame && shot_latch;

    // The missile is gone after hitting the target or leaving through the top
    assign remove = collision || edge_code.top;

    // A shot held at any time in the frame is kept until the next tick
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            shot_latch <= 1'b0;
        end else if (start_of_frame) begin
            shot_latch <= 1'b0;
        end else if (shot) begin
            shot_latch <= 1'b1;
        end
    end

    // Launch takes priority over removal, removal over flight
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            x_fp  <= '0;
            y_fp  <= '0;
            state <= MS_IDLE;
        end else begin
            if (launch) begin
                x_fp  <= launch_x;
                y_fp  <= launch_y;
                state <= MS_FLYING;
            end else if (remove) begin
                x_fp  <= '0;
                y_fp  <= '0;
                state <= MS_IDLE;
            end else if (start_of_frame && (state == MS_FLYING)) begin
                // One frame of flight at the fixed speed
                x_fp <= x_fp + fixed_t'(`MISSILE_X_SPEED);
                y_fp <= y_fp + fixed_t'(`MISSILE_Y_SPEED);
            end
        end
    end

    assign missile_active = (state == MS_FLYING);

    // Drop the fraction; the arithmetic shift keeps negative positions negative
    assign missile_pos = '{
        x: coord_t'(x_fp >>> `FP_SHIFT),
        y: coord_t'(y_fp >>> `FP_SHIFT)
    };

    // A missile only appears on a frame tick
    assert property (@(posedge clk) disable iff (!resetN)
        (state == MS_IDLE) && !start_of_frame |=> (state == MS_IDLE))
        else $error("missile launched without a frame tick");

endmodule

`default_nettype wire

/* ship_movement.sv */
`timescale 1ns/1ps
`default_nettype none

`include "shooter_params.svh"

module ship_movement (
    input  logic                       clk,
    input  logic                       resetN,
    input  logic                       start_of_frame,
    input  shooter_ctrl_pkg::keys_t    keys,
    output shooter_geom_pkg::obj_pos_t ship_pos
);

    import shooter_geom_pkg::*;
    import shooter_ctrl_pkg::*;

    ship_dir_e dir;
    coord_t    ship_x;
    coord_t    next_x;

    // Only one key held gives a direction; both or neither keep the ship still
    always_comb begin
        case ({keys.left, keys.right})
            2'b10:   dir = DIR_LEFT;
            2'b01:   dir = DIR_RIGHT;
            default: dir = DIR_NONE;
        endcase
    end

    // One step in the chosen direction, saturated at the screen edges
    always_comb begin
        next_x = ship_x;
        case (dir)
            DIR_LEFT: begin
                if (ship_x < coord_t'(`SHIP_STEP)) begin
                    next_x = '0;
                end else begin
                    next_x = ship_x - coord_t'(`SHIP_STEP);
                end
            end
            DIR_RIGHT: begin
                // The ship's right side may touch the right border but not pass it
                if (ship_x > coord_t'(`SCREEN_W - `SHIP_W - `SHIP_STEP)) begin
                    next_x = coord_t'(`SCREEN_W - `SHIP_W);
                end else begin
                    next_x = ship_x + coord_t'(`SHIP_STEP);
                end
            end
            default: begin
                next_x = ship_x;
            end
        endcase
    end

    // X only updates on the frame tick, keys in between are ignored
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            ship_x <= coord_t'(`SHIP_START_X);
        end else if (start_of_frame) begin
            ship_x <= next_x;
        end
    end

    // The ship lives on a fixed row
    assign ship_pos = '{x: ship_x, y: coord_t'(`SHIP_Y)};

    // The ship box never leaves the screen
    assert property (@(posedge clk) disable iff (!resetN)
        (ship_x >= 0) && (ship_x <= coord_t'(`SCREEN_W - `SHIP_W)))
        else $error("ship_pos.x out of screen: %0d", ship_x);

endmodule

`default_nettype wire

/* shooter_ctrl_pkg.sv */
`default_nettype none

package shooter_ctrl_pkg;

    // Key levels as they come from the keypad
    typedef struct packed {
        logic left;
        logic right;
        logic shot;
    } keys_t;

    // Decoded ship motion for one frame
    typedef enum logic [1:0] {
        DIR_NONE,
        DIR_LEFT,
        DIR_RIGHT
    } ship_dir_e;

    // Missile life cycle
    typedef enum logic {
        MS_IDLE,
        MS_FLYING
    } missile_state_e;

endpackage

`default_nettype wire

/* shooter_geom_pkg.sv */
`default_nettype none

`include "shooter_params.svh"

package shooter_geom_pkg;

    // One screen coordinate, signed so an object may sit partly off screen
    typedef logic signed [`PIXEL_WIDTH-1:0] coord_t;

    // One extra bit so that a coordinate plus an object size cannot overflow
    typedef logic signed [`PIXEL_WIDTH:0] wide_coord_t;

    // Top-left corner of an object on the screen
    typedef struct packed {
        coord_t x;
        coord_t y;
    } obj_pos_t;

    // Screen borders that the missile box currently crosses
    typedef struct packed {
        logic top;
        logic bottom;
        logic left;
        logic right;
    } edge_code_t;

endpackage

`default_nettype wire

/* shooter_params.svh */
`ifndef SHOOTER_PARAMS_SVH
`define SHOOTER_PARAMS_SVH

// Visible screen in pixels
`define SCREEN_W          640
`define SCREEN_H          480

// Signed coordinate width, wide enough for objects partly off screen
`define PIXEL_WIDTH       11

// Positions move in 1/64 pixel steps, so the fraction takes 6 bits
`define FP_SHIFT          6

// Clocks between two frame ticks, kept short for simulation
`define FRAME_CYCLES      32

// Ship geometry and motion
`define SHIP_STEP         8
`define SHIP_W            32
`define SHIP_H            32
`define SHIP_START_X      304
`define SHIP_Y            440

// Missile motion in 1/64 pixel per frame; negative Y flies up the screen
`define MISSILE_X_SPEED   0
`define MISSILE_Y_SPEED   -256
`define MISSILE_X_OFFSET  15
`define MISSILE_Y_OFFSET  0
`define MISSILE_W         4
`define MISSILE_H         8

// Target box
`define TARGET_W          32
`define TARGET_H          16

`endif

/* shooter_top.sv */
`timescale 1ns/1ps
`default_nettype none

module shooter_top (
    input  logic                       clk,
    input  logic                       resetN,
    input  shooter_ctrl_pkg::keys_t    keys,
    input  shooter_geom_pkg::obj_pos_t target_pos,
    output logic                       start_of_frame,
    output shooter_geom_pkg::obj_pos_t ship_pos,
    output shooter_geom_pkg::obj_pos_t missile_pos,
    output logic                       missile_active,
    output logic                       hit
);

    import shooter_geom_pkg::*;

    // Missile border flags fed back from the detector
    edge_code_t edge_code;

    // Frame rate strobe for all moving objects
    frame_tick_gen u_frame_tick_gen (
        .clk            (clk),
        .resetN         (resetN),
        .start_of_frame (start_of_frame)
    );

    ship_movement u_ship_movement (
        .clk            (clk),
        .resetN         (resetN),
        .start_of_frame (start_of_frame),
        .keys           (keys),
        .ship_pos       (ship_pos)
    );

    // The hit pulse doubles as the missile's removal request
    missile_movement u_missile_movement (
        .clk            (clk),
        .resetN         (resetN),
        .start_of_frame (start_of_frame),
        .shot           (keys.shot),
        .collision      (hit),
        .edge_code      (edge_code),
        .ship_pos       (ship_pos),
        .missile_pos    (missile_pos),
        .missile_active (missile_active)
    );

    hit_detector u_hit_detector (
        .clk            (clk),
        .resetN         (resetN),
        .missile_pos    (missile_pos),
        .missile_active (missile_active),
        .target_pos     (target_pos),
        .collision      (hit),
        .edge_code      (edge_code)
    );

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
shooter_geom_pkg.sv
shooter_ctrl_pkg.sv
frame_tick_gen.sv
ship_movement.sv
missile_movement.sv
hit_detector.sv
shooter_top.sv
tb_shooter.sv

/* tb_shooter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "shooter_params.svh"

module tb_shooter;

    import shooter_geom_pkg::*;
    import shooter_ctrl_pkg::*;

    localparam int TICK_TIMEOUT   = `FRAME_CYCLES + 4;
    localparam int HIT_TIMEOUT    = 80 * `FRAME_CYCLES;
    localparam int FLIGHT_TIMEOUT = 130 * `FRAME_CYCLES;

    logic     clk = 1'b0;
    logic     resetN;
    keys_t    keys;
    obj_pos_t target_pos;
    logic     start_of_frame;
    obj_pos_t ship_pos;
    obj_pos_t missile_pos;
    logic     missile_active;
    logic     hit;

    // Reference model state
    int   cyc_since_rel;
    logic exp_sof;
    int   exp_ship_x;
    logic exp_latch;
    int   exp_x_fp;
    int   exp_y_fp;
    logic exp_active;
    logic exp_hit;
    int   exp_mx;
    int   exp_my;
    logic exp_top;

    int value_errs = 0;
    int timeout_errs = 0;
    int hit_cnt = 0;

    shooter_top UUT (
        .clk            (clk),
        .resetN         (resetN),
        .keys           (keys),
        .target_pos     (target_pos),
        .start_of_frame (start_of_frame),
        .ship_pos       (ship_pos),
        .missile_pos    (missile_pos),
        .missile_active (missile_active),
        .hit            (hit)
    );

    always #10 clk = ~clk;

    // One key alone moves the ship one step, and the ship box stays on screen
    function automatic int stepped_ship_x(int x, logic left, logic right);
        int nx;
        nx = x;
        if (left && !right) begin
            nx = x - `SHIP_STEP;
        end else if (right && !left) begin
            nx = x + `SHIP_STEP;
        end
        if (nx < 0) begin
            nx = 0;
        end
        if (nx > `SCREEN_W - `SHIP_W) begin
            nx = `SCREEN_W - `SHIP_W;
        end
        return nx;
    endfunction

    // Right and bottom sides are exclusive
    function automatic logic boxes_overlap(int mx, int my, int tx, int ty);
        return (mx < tx + `TARGET_W) && (tx < mx + `MISSILE_W)
            && (my < ty + `TARGET_H) && (ty < my + `MISSILE_H);
    endfunction

    // Pixel position of the model missile and its top border flag
    always_comb begin
        exp_mx  = exp_x_fp >>> `FP_SHIFT;
        exp_my  = exp_y_fp >>> `FP_SHIFT;
        exp_top = exp_active && (exp_my < 0);
    end

    always @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            cyc_since_rel <= 0;
            exp_sof       <= 1'b0;
            exp_ship_x    <= `SHIP_START_X;
            exp_latch     <= 1'b0;
            exp_x_fp      <= 0;
            exp_y_fp      <= 0;
            exp_active    <= 1'b0;
            exp_hit       <= 1'b0;
        end else begin
            // A tick every FRAME_CYCLES clocks, the first one FRAME_CYCLES after release
            cyc_since_rel <= cyc_since_rel + 1;
            exp_sof       <= ((cyc_since_rel + 1) % `FRAME_CYCLES) == 0;
            if (exp_sof) begin
                exp_ship_x <= stepped_ship_x(exp_ship_x, keys.left, keys.right);
                exp_latch  <= 1'b0;
            end else if (keys.shot) begin
                exp_latch <= 1'b1;
            end
            // Launch beats removal, removal beats flight
            if (exp_sof && exp_latch) begin
                exp_x_fp   <= (exp_ship_x + `MISSILE_X_OFFSET) * (1 << `FP_SHIFT);
                exp_y_fp   <= (`SHIP_Y + `MISSILE_Y_OFFSET) * (1 << `FP_SHIFT);
                exp_active <= 1'b1;
            end else if (exp_hit || exp_top) begin
                exp_x_fp   <= 0;
                exp_y_fp   <= 0;
                exp_active <= 1'b0;
            end else if (exp_sof && exp_active) begin
                exp_x_fp <= exp_x_fp + (`MISSILE_X_SPEED);
                exp_y_fp <= exp_y_fp + (`MISSILE_Y_SPEED);
            end
            // A hit lasts one cycle even though the boxes still overlap after it
            exp_hit <= exp_active && !exp_hit
                    && boxes_overlap(exp_mx, exp_my, target_pos.x, target_pos.y);
        end
    end

    always @(negedge clk) begin
        if (resetN && hit) begin
            hit_cnt++;
        end
    end

    chk_sof: assert property (@(posedge clk) disable iff (!resetN)
        start_of_frame == exp_sof)
        else begin
            value_errs++;
            $display("[FAIL] t=%0t signal=start_of_frame expected=%0b actual=%0b",
                     $time, $sampled(exp_sof), $sampled(start_of_frame));
        end

    chk_ship_x: assert property (@(posedge clk) disable iff (!resetN)
        int'(ship_pos.x) == exp_ship_x)
        else begin
            value_errs++;
            $display("[FAIL] t=%0t signal=ship_pos.x expected=%0d actual=%0d",
                     $time, $sampled(exp_ship_x), $sampled(ship_pos.x));
        end

    chk_ship_y: assert property (@(posedge clk) disable iff (!resetN)
        int'(ship_pos.y) == `SHIP_Y)
        else begin
            value_errs++;
            $display("[FAIL] t=%0t signal=ship_pos.y expected=%0d actual=%0d",
                     $time, `SHIP_Y, $sampled(ship_pos.y));
        end

    chk_active: assert property (@(posedge clk) disable iff (!resetN)
        missile_active == exp_active)
        else begin
            value_errs++;
            $display("[FAIL] t=%0t signal=missile_active expected=%0b actual=%0b",
                     $time, $sampled(exp_active), $sampled(missile_active));
        end

    chk_missile_x: assert property (@(posedge clk) disable iff (!resetN)
        int'(missile_pos.x) == exp_mx)
        else begin
            value_errs++;
            $display("[FAIL] t=%0t signal=missile_pos.x expected=%0d actual=%0d",
                     $time, $sampled(exp_mx), $sampled(missile_pos.x));
        end

    chk_missile_y: assert property (@(posedge clk) disable iff (!resetN)
        int'(missile_pos.y) == exp_my)
        else begin
            value_errs++;
            $display("[FAIL] t=%0t signal=missile_pos.y expected=%0d actual=%0d",
                     $time, $sampled(exp_my), $sampled(missile_pos.y));
        end

    chk_hit: assert property (@(posedge clk) disable iff (!resetN)
        hit == exp_hit)
        else begin
            value_errs++;
            $display("[FAIL] t=%0t signal=hit expected=%0b actual=%0b",
                     $time, $sampled(exp_hit), $sampled(hit));
        end

    // Without a re-fire the missile is gone one edge after the hit
    chk_clear_after_hit: assert property (@(posedge clk) disable iff (!resetN)
        hit && !(exp_sof && exp_latch) |=> !missile_active)
        else begin
            value_errs++;
            $display("Missile was still active one edge after a hit at %0t", $time);
        end

    task automatic finish_run();
        $display("Errors: %0d value, %0d timeout", value_errs, timeout_errs);
        if (value_errs == 0 && timeout_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    // Runs to the rising edge of the next frame tick and 2 ns past it
    task automatic wait_tick();
        int n;
        n = 0;
        @(negedge clk);
        while (!start_of_frame && n < TICK_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!start_of_frame) begin
            timeout_errs++;
            $display("Timeout: no frame tick within %0d clocks at %0t", TICK_TIMEOUT, $time);
        end else begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic wait_hit();
        int n;
        n = 0;
        @(negedge clk);
        while (!hit && n < HIT_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!hit) begin
            timeout_errs++;
            $display("Timeout: the missile never hit the target within %0d clocks", HIT_TIMEOUT);
        end else begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic wait_active(logic level, int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (missile_active !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (missile_active !== level) begin
            timeout_errs++;
            $display("Timeout: missile_active did not become %0b within %0d clocks",
                     level, limit);
        end else begin
            @(posedge clk);
            #2;
        end
    endtask

    // One-clock shot press a few clocks into the frame
    task automatic press_shot();
        repeat (3) @(posedge clk);
        #2;
        keys.shot = 1'b1;
        @(posedge clk);
        #2;
        keys.shot = 1'b0;
    endtask

    initial begin
        void'($urandom(49));
        resetN     = 1'b0;
        keys       = '0;
        target_pos = '{x: coord_t'(-200), y: coord_t'(-200)};
        repeat (8) @(posedge clk);
        #2;
        resetN = 1'b1;

        // Idle frames check the tick spacing and the reset values
        repeat (3) wait_tick();

        // Held keys drive the ship into both clamps, then random key levels
        keys.left = 1'b1;
        repeat (42) wait_tick();
        keys.left  = 1'b0;
        keys.right = 1'b1;
        repeat (80) wait_tick();
        repeat (24) begin
            keys.left  = 1'($urandom % 2);
            keys.right = 1'($urandom % 2);
            wait_tick();
        end
        keys = '0;
        wait_tick();

        // Launch, a few frames of flight, then a re-fire from a moved ship
        press_shot();
        wait_tick();
        repeat (3) wait_tick();
        keys.left = 1'b1;
        repeat (2) wait_tick();
        keys.left = 1'b0;
        press_shot();
        wait_tick();
        wait_tick();

        // Target straight above the ship so the next missile hits it
        target_pos = '{x: ship_pos.x, y: coord_t'(200)};
        press_shot();
        wait_hit();
        wait_active(1'b0, TICK_TIMEOUT);
        if (hit_cnt != 1) begin
            value_errs++;
            $display("[FAIL] t=%0t signal=hit_count expected=1 actual=%0d", $time, hit_cnt);
        end

        // Target out of the path, the missile leaves through the top border
        if (ship_pos.x < 320) begin
            target_pos = '{x: coord_t'(560), y: coord_t'(100)};
        end else begin
            target_pos = '{x: coord_t'(0), y: coord_t'(100)};
        end
        press_shot();
        wait_active(1'b1, 2 * TICK_TIMEOUT);
        wait_active(1'b0, FLIGHT_TIMEOUT);
        if (hit_cnt != 1) begin
            value_errs++;
            $display("[FAIL] t=%0t signal=hit_count expected=1 actual=%0d", $time, hit_cnt);
        end
        repeat (2) wait_tick();
        finish_run();
    end

endmodule

`default_nettype wire
